//--- periph_pkg.sv
// Peripheral hub definitions
package periph_pkg;

    // Bus and pin widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int OFS_W  = 6;
    localparam int PIN_W  = 8;
    localparam int FSEL_W = 6;

    // Slot counts
    localparam int USER_SLOTS   = 24;
    localparam int SIMPLE_SLOTS = 16;
    localparam int SIMPLE_IDX_W = $clog2(SIMPLE_SLOTS);

    // Slot number, wide enough for every full slot
    typedef logic [4:0] slot_idx_t;

    // Populated and reserved full slots
    localparam slot_idx_t GPIO_SLOT = 5'd1;
    localparam slot_idx_t UART_SLOT = 5'd2;

    // GPIO register offsets inside its slot
    localparam logic [OFS_W-1:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [OFS_W-1:0] GPIO_IN_OFS    = 6'h04;
    // One word per pin selector, pins 0 to 7
    localparam logic [OFS_W-1:0] GPIO_FSEL_BASE = 6'h20;
    // Offset bits that must match the base for a selector hit
    localparam logic [OFS_W-1:0] GPIO_FSEL_MASK = 6'h23;

    // Access size codes from the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } bus_size_e;

    // Kind of slot an address falls into
    typedef enum logic {
        SLOT_USER   = 1'b0,
        SLOT_SIMPLE = 1'b1
    } slot_kind_e;

endpackage

//--- periph_addr_decoder.sv
// Peripheral address decoder
`timescale 1ns/1ps

module periph_addr_decoder (
    input  logic [periph_pkg::ADDR_W-1:0] i_addr,
    input  periph_pkg::bus_size_e         i_write_n,
    input  periph_pkg::bus_size_e         i_read_n,
    output periph_pkg::slot_kind_e        o_slot_kind,
    output periph_pkg::slot_idx_t         o_slot_idx,
    output logic                          o_gpio_sel,
    output logic                          o_wr_en,
    output logic                          o_rd_req
);
    import periph_pkg::*;

    // Three-way split of the address space
    always_comb begin
        if (i_addr[10:9] == 2'b10) begin
            // Byte slots, 16 bytes each
            o_slot_kind = SLOT_SIMPLE;
            o_slot_idx  = slot_idx_t'(i_addr[4 +: SIMPLE_IDX_W]);
        end else if (i_addr[10]) begin
            // Upper bank of full slots starts at 16
            o_slot_kind = SLOT_USER;
            o_slot_idx  = {2'b10, i_addr[8:6]};
        end else begin
            o_slot_kind = SLOT_USER;
            o_slot_idx  = {1'b0, i_addr[9:6]};
        end
    end

    assign o_gpio_sel = (o_slot_kind == SLOT_USER) && (o_slot_idx == GPIO_SLOT);

    // Any size code other than none is an access
    assign o_wr_en  = (i_write_n != SIZE_NONE);
    assign o_rd_req = (i_read_n != SIZE_NONE);

endmodule

//--- periph_read_buffer.sv
// Read data buffer
`timescale 1ns/1ps

module periph_read_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_rd_req,
    input  logic [periph_pkg::DATA_W-1:0] i_slot_data,
    input  logic                          i_data_read_complete,
    output logic [periph_pkg::DATA_W-1:0] o_data,
    output logic                          o_data_ready
);
    import periph_pkg::*;

    logic [DATA_W-1:0] data_q;
    logic              hold_q;
    logic              ready_q;
    logic              capture;

    // Take a new value only while nothing is buffered
    assign capture = i_rd_req && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Every slot answers at once, so ready just follows the request
            ready_q <= i_rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_slot_data;
        end
    end

    assign o_data       = data_q;
    assign o_data_ready = ready_q;

endmodule

//--- gpio_regs.sv
// GPIO registers and pin routing
`timescale 1ns/1ps

module gpio_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_gpio_sel,
    input  logic                          i_wr_en,
    input  logic [periph_pkg::OFS_W-1:0]  i_offset,
    input  logic [periph_pkg::PIN_W-1:0]  i_wdata,
    input  logic [periph_pkg::PIN_W-1:0]  i_ui_in,
    output logic [periph_pkg::DATA_W-1:0] o_rdata,
    output logic [periph_pkg::PIN_W-1:0]  o_uo_out
);
    import periph_pkg::*;

    logic [PIN_W-1:0]  out_q;
    logic [FSEL_W-1:0] fsel_q [PIN_W];
    logic              fsel_hit;
    logic [2:0]        fsel_pin;

    // Selector encoding of a full slot number
    function automatic logic [FSEL_W-1:0] user_code(input slot_idx_t slot);
        return {slot[4], 1'b0, slot[3:0]};
    endfunction

    // True when a selector names the GPIO slot
    function automatic logic names_gpio(input logic [FSEL_W-1:0] sel);
        slot_kind_e kind;
        slot_idx_t  idx;
        kind = sel[4] ? SLOT_SIMPLE : SLOT_USER;
        idx  = sel[4] ? {1'b0, sel[3:0]} : {sel[5], sel[3:0]};
        return (kind == SLOT_USER) && (idx == GPIO_SLOT);
    endfunction

    assign fsel_hit = ((i_offset & GPIO_FSEL_MASK) == GPIO_FSEL_BASE);
    assign fsel_pin = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (i_gpio_sel && i_wr_en && i_offset == GPIO_OUT_OFS) begin
            out_q <= i_wdata;
        end
    end

    // Pins 0 and 1 come up on the UART slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < PIN_W; p++) begin
                fsel_q[p] <= (p < 2) ? user_code(UART_SLOT) : user_code(GPIO_SLOT);
            end
        end else if (i_gpio_sel && i_wr_en && fsel_hit) begin
            fsel_q[fsel_pin] <= i_wdata[FSEL_W-1:0];
        end
    end

    // Read mux, zero-extended
    always_comb begin
        o_rdata = '0;
        if (i_offset == GPIO_OUT_OFS) begin
            o_rdata = DATA_W'(out_q);
        end else if (i_offset == GPIO_IN_OFS) begin
            o_rdata = DATA_W'(i_ui_in);
        end else if (fsel_hit) begin
            o_rdata = DATA_W'(fsel_q[fsel_pin]);
        end
    end

    // Only GPIO is populated, so every other source drives zero
    always_comb begin
        for (int p = 0; p < PIN_W; p++) begin
            o_uo_out[p] = names_gpio(fsel_q[p]) ? out_q[p] : 1'b0;
        end
    end

endmodule

//--- periph_hub_top.sv
// Peripheral hub top level
`timescale 1ns/1ps

module periph_hub_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [periph_pkg::ADDR_W-1:0] i_addr,
    input  logic [periph_pkg::DATA_W-1:0] i_data,
    input  periph_pkg::bus_size_e         i_write_n,
    input  periph_pkg::bus_size_e         i_read_n,
    output logic [periph_pkg::DATA_W-1:0] o_data,
    output logic                          o_data_ready,
    input  logic                          i_data_read_complete,
    input  logic [periph_pkg::PIN_W-1:0]  i_ui_in,
    output logic [periph_pkg::PIN_W-1:0]  o_uo_out
);
    import periph_pkg::*;

    logic              gpio_sel;
    logic              wr_en;
    logic              rd_req;
    logic [DATA_W-1:0] gpio_rdata;
    logic [DATA_W-1:0] slot_data;
    logic              buf_ready;

    periph_addr_decoder u_decoder (
        .i_addr      (i_addr),
        .i_write_n   (i_write_n),
        .i_read_n    (i_read_n),
        .o_slot_kind (),
        .o_slot_idx  (),
        .o_gpio_sel  (gpio_sel),
        .o_wr_en     (wr_en),
        .o_rd_req    (rd_req)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_gpio_sel (gpio_sel),
        .i_wr_en    (wr_en),
        .i_offset   (i_addr[OFS_W-1:0]),
        .i_wdata    (i_data[PIN_W-1:0]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_uo_out   (o_uo_out)
    );

    // Every slot other than GPIO is empty and reads zero
    assign slot_data = gpio_sel ? gpio_rdata : '0;

    periph_read_buffer u_read_buf (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_rd_req             (rd_req),
        .i_slot_data          (slot_data),
        .i_data_read_complete (i_data_read_complete),
        .o_data               (o_data),
        .o_data_ready         (buf_ready)
    );

    // Writes are acknowledged in the same cycle
    assign o_data_ready = buf_ready || wr_en;

endmodule

//--- periph_hub_tb.sv
// Peripheral hub testbench
`timescale 1ns/1ps

module periph_hub_tb;
    import periph_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int READY_TIMEOUT = 20;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    bus_size_e         write_n;
    bus_size_e         read_n;
    logic [DATA_W-1:0] rdata;
    logic              data_ready;
    logic              read_complete;
    logic [PIN_W-1:0]  ui_in;
    logic [PIN_W-1:0]  uo_out;

    integer seed;
    int     checks_done;

    periph_hub_top UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (addr),
        .i_data               (wdata),
        .i_write_n            (write_n),
        .i_read_n             (read_n),
        .o_data               (rdata),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected,
                               input string what);
        checks_done++;
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // Write is acknowledged in its own cycle and lands on the next rising edge
    task automatic do_write(input bus_size_e size, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d);
        @(negedge clk);
        addr    = a;
        wdata   = d;
        write_n = size;
        #(CLK_PERIOD / 4);
        check_value(DATA_W'(data_ready), 32'd1, $sformatf("write ack at %h", a));
        @(negedge clk);
        write_n = SIZE_NONE;
    endtask

    // Read with a delayed completion while the input pins keep moving
    task automatic do_read(input bus_size_e size, input logic [ADDR_W-1:0] a,
                           input logic [PIN_W-1:0] pins, input logic [DATA_W-1:0] expected);
        int   wait_cycles;
        int   hold_cycles;
        logic ready_seen;
        @(negedge clk);
        addr   = a;
        ui_in  = pins;
        read_n = size;
        // Ready must stay low until an edge has sampled the request
        #(CLK_PERIOD / 4);
        check_value(DATA_W'(data_ready), 32'd0, $sformatf("ready before first edge at %h", a));
        wait_cycles = 0;
        ready_seen  = 1'b0;
        while (!ready_seen) begin
            @(negedge clk);
            wait_cycles++;
            if (data_ready) begin
                ready_seen = 1'b1;
            end else if (wait_cycles >= READY_TIMEOUT) begin
                abort_run($sformatf("timeout at %0t ns: ready never came for read at %h",
                                    $time, a));
            end
        end
        check_value(DATA_W'(wait_cycles), 32'd1, $sformatf("ready latency at %h", a));
        check_value(rdata, expected, $sformatf("read data at %h", a));
        hold_cycles = 2 + int'($unsigned($random(seed)) % 32'd4);
        for (int c = 0; c < hold_cycles; c++) begin
            ui_in = PIN_W'($random(seed));
            @(negedge clk);
            check_value(rdata, expected, $sformatf("held read data at %h", a));
            check_value(DATA_W'(data_ready), 32'd1, "ready while read is held");
        end
        read_complete = 1'b1;
        read_n        = SIZE_NONE;
        @(negedge clk);
        read_complete = 1'b0;
    endtask

    task automatic check_pins(input logic [PIN_W-1:0] expected);
        @(negedge clk);
        check_value(DATA_W'(uo_out), DATA_W'(expected), "output pins");
    endtask

    initial begin : replay
        int               fd;
        int               n;
        int               line_no;
        logic [8*128-1:0] line_buf;
        logic [7:0]       op;
        logic [31:0]      v_size;
        logic [31:0]      v_addr;
        logic [31:0]      v_data;
        logic [31:0]      v_exp;
        seed          = 32'hf29d;
        checks_done   = 0;
        rst_n         = 1'b0;
        addr          = '0;
        wdata         = '0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        ui_in         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("periph_hub_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the vector file periph_hub_vectors.txt");
        end
        line_no = 0;
        while ($fgets(line_buf, fd) != 0) begin
            line_no++;
            n = $sscanf(line_buf, " %c %h %h %h %h", op, v_size, v_addr, v_data, v_exp);
            // Blank lines and comment lines carry no step
            if (n > 0 && op != "#") begin
                if (n != 5) begin
                    abort_run($sformatf("vector line %0d is malformed", line_no));
                end else begin
                    case (op)
                        "W": do_write(bus_size_e'(v_size[1:0]), v_addr[ADDR_W-1:0], v_data);
                        "R": do_read(bus_size_e'(v_size[1:0]), v_addr[ADDR_W-1:0],
                                     v_data[PIN_W-1:0], v_exp);
                        "P": check_pins(v_exp[PIN_W-1:0]);
                        default: abort_run($sformatf("vector line %0d has unknown operation",
                                                     line_no));
                    endcase
                end
            end
        end
        $fclose(fd);

        if (checks_done == 0) begin
            abort_run("no vectors were applied");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- periph_hub_vectors.txt
# op size addr data expected, hex; op W write, R read, P output pin check
# R drives the data column on the input pins, P uses only the expected column
R 2 040 00 00
R 2 060 00 02
R 2 064 00 02
R 2 068 00 01
R 2 06c 00 01
R 2 070 00 01
R 2 074 00 01
R 2 078 00 01
R 2 07c 00 01
P 0 000 00 00
W 0 040 ff 00
P 0 000 00 fc
W 1 040 1234 00
R 2 040 00 34
P 0 000 00 34
W 2 040 deadbea5 00
R 0 040 00 a5
P 0 000 00 a4
R 2 044 5a 5a
R 0 044 c3 c3
W 2 060 01 00
P 0 000 00 a5
R 2 060 00 01
W 2 060 15 00
P 0 000 00 a4
R 2 060 00 15
W 2 068 05 00
P 0 000 00 a0
R 2 068 00 05
W 2 06c ffffff21 00
R 2 06c 00 21
W 2 068 01 00
W 2 064 01 00
W 0 040 0f 00
P 0 000 00 06
R 2 450 ff 00
R 2 640 ff 00
R 2 000 ff 00
R 2 080 ff 00
R 2 048 ff 00
R 2 07e ff 00
W 2 400 ff 00
W 2 640 ff 00
W 2 660 01 00
W 2 000 ff 00
W 2 048 ff 00
R 2 040 00 0f
R 2 060 00 15
R 2 064 00 01
P 0 000 00 06
R 2 044 3c 3c
R 2 044 81 81

//--- src.f
periph_pkg.sv
periph_addr_decoder.sv
periph_read_buffer.sv
gpio_regs.sv
periph_hub_top.sv
periph_hub_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = periph_hub_tb
FILELIST  = src.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
